// ==== msk_alu.f ====
msk_alu_pkg.sv
msk_prng.sv
msk_logic.sv
msk_addsub.sv
msk_alu_ctl.sv
msk_alu.sv
msk_alu_props.sv
tb_msk_alu.sv

// ==== tb_msk_alu.sv ====
`timescale 1ns/1ps

module tb_msk_alu;
  import msk_alu_pkg::*;

  logic            g_clk = 1'b0;
  logic            g_resetn;
  logic            i_valid;
  logic            i_flush;
  logic            i_prng_update;
  msk_op_t         i_op;
  share_t          i_rs1;
  share_t          i_rs2;
  logic            o_ready;
  share_t          o_rd;
  logic [XLEN-1:0] rng_state = 32'h927f_912c;

  msk_alu u_msk_alu (
    .g_clk         (g_clk),
    .g_resetn      (g_resetn),
    .i_valid       (i_valid),
    .i_flush       (i_flush),
    .i_prng_update (i_prng_update),
    .i_op          (i_op),
    .i_rs1         (i_rs1),
    .i_rs2         (i_rs2),
    .o_ready       (o_ready),
    .o_rd          (o_rd)
  );

  always #4 g_clk = ~g_clk; // 8 ns period

  function automatic logic [XLEN-1:0] xorshift32(input logic [XLEN-1:0] x);
    logic [XLEN-1:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw_word(output logic [XLEN-1:0] w);
    rng_state = xorshift32(rng_state);
    w = rng_state;
  endtask

  // Index order 0 NOT, 1 AND, 2 OR, 3 XOR, 4 ADD, 5 SUB
  function automatic msk_op_t op_code(input int idx);
    return msk_op_t'(6'b100000 >> idx);
  endfunction

  function automatic string op_name(input int idx);
    case (idx)
      0:       return "NOT";
      1:       return "AND";
      2:       return "OR";
      3:       return "XOR";
      4:       return "ADD";
      default: return "SUB";
    endcase
  endfunction

  // Plain reference model
  function automatic logic [XLEN-1:0] expected_result(input int idx,
                                                      input logic [XLEN-1:0] a, b);
    case (idx)
      0:       return ~a;
      1:       return a & b;
      2:       return a | b;
      3:       return a ^ b;
      4:       return a + b;
      default: return a - b;
    endcase
  endfunction

  function automatic share_t make_share(input logic [XLEN-1:0] plain, mask);
    share_t s;
    s.s0 = plain ^ mask;
    s.s1 = mask;
    return s;
  endfunction

  task automatic stop_on_error();
    $display("Test failures found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_eq(input string name, input logic [XLEN-1:0] got, exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  // Full handshake, result sampled at the falling edge before the ready edge
  task automatic do_op(input int idx, input logic [XLEN-1:0] a, b, ma, mb,
                       output logic [XLEN-1:0] plain, output int cycles);
    @(negedge g_clk);
    i_valid = 1'b1;
    i_op    = op_code(idx);
    i_rs1   = make_share(a, ma);
    i_rs2   = make_share(b, mb);
    cycles  = 0;
    do begin
      @(negedge g_clk);
      cycles++;
    end while (!o_ready && cycles < 16);
    if (!o_ready) begin
      $display("Timeout: %s got no ready within 16 cycles", op_name(idx));
      stop_on_error();
    end else begin
      plain = o_rd.s0 ^ o_rd.s1;
      @(posedge g_clk);
      @(negedge g_clk);
      i_valid = 1'b0;
      i_op    = '0;
    end
  endtask

  task automatic run_checked(input int idx, input logic [XLEN-1:0] a, b, ma, mb,
                             output logic [XLEN-1:0] plain);
    int cycles;
    do_op(idx, a, b, ma, mb, plain, cycles);
    check_eq({"o_rd plain ", op_name(idx)}, plain, expected_result(idx, a, b));
    if (idx < 4) begin
      check_eq({"ready latency ", op_name(idx)}, cycles, 1);
    end
  endtask

  task automatic run_random(input int idx, input int count);
    logic [XLEN-1:0] a, b, ma, mb, plain;
    repeat (count) begin
      draw_word(a);
      draw_word(b);
      draw_word(ma);
      draw_word(mb);
      run_checked(idx, a, b, ma, mb, plain);
    end
  endtask

  task automatic run_corner_operands();
    logic [XLEN-1:0] corner [3];
    logic [XLEN-1:0] ma, mb, plain;
    int op, i, j;
    corner = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000};
    for (op = 4; op < 6; op++) begin
      for (i = 0; i < 3; i++) begin
        for (j = 0; j < 3; j++) begin
          draw_word(ma);
          draw_word(mb);
          run_checked(op, corner[i], corner[j], ma, mb, plain);
        end
      end
    end
  endtask

  // Same plain operands under two mask sets
  task automatic run_mask_independence();
    logic [XLEN-1:0] a, b, ma, mb, first, second;
    int idx;
    int cycles;
    for (idx = 0; idx < 6; idx++) begin
      draw_word(a);
      draw_word(b);
      draw_word(ma);
      draw_word(mb);
      run_checked(idx, a, b, ma, mb, first);
      @(negedge g_clk);
      i_prng_update = 1'b1; // Extra LFSR step
      @(negedge g_clk);
      i_prng_update = 1'b0;
      draw_word(ma);
      draw_word(mb);
      do_op(idx, a, b, ma, mb, second, cycles);
      check_eq({"remasked ", op_name(idx)}, second, first);
    end
  endtask

  task automatic run_flush_abort();
    logic [XLEN-1:0] a, b, ma, mb, plain;
    draw_word(a);
    draw_word(b);
    draw_word(ma);
    draw_word(mb);
    @(negedge g_clk);
    i_valid = 1'b1;
    i_op    = op_code(4);
    i_rs1   = make_share(a, ma);
    i_rs2   = make_share(b, mb);
    repeat (3) @(negedge g_clk);
    i_flush = 1'b1; // Abort while the carry steps run
    // Held past the cycle where the ADD would otherwise finish
    repeat (4) begin
      @(negedge g_clk);
      check_eq("o_ready during flush", o_ready, 1'b0);
    end
    i_flush = 1'b0;
    i_valid = 1'b0;
    i_op    = '0;
    run_random(3, 1);
    run_random(4, 1);
  endtask

  initial begin
    int idx;
    g_resetn      = 1'b0;
    i_valid       = 1'b0;
    i_flush       = 1'b0;
    i_prng_update = 1'b0;
    i_op          = '0;
    i_rs1         = '0;
    i_rs2         = '0;
    repeat (8) @(posedge g_clk);
    @(negedge g_clk);
    g_resetn = 1'b1;
    i_op     = op_code(3); // Operation present but never made valid
    repeat (10) begin
      @(negedge g_clk);
      check_eq("o_ready after reset", o_ready, 1'b0);
    end
    i_op = '0;
    for (idx = 0; idx < 6; idx++) begin
      run_random(idx, 20);
    end
    run_corner_operands();
    run_mask_independence();
    run_flush_abort();
    repeat (2) @(negedge g_clk);
    if (u_msk_alu.u_props.fail_count != 0) begin
      $display("Bound assertions failed %0d times", u_msk_alu.u_props.fail_count);
      stop_on_error();
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

// ==== msk_alu_props.sv ====
`timescale 1ns/1ps

module msk_alu_props (
  input logic                         g_clk,
  input logic                         g_resetn,
  input logic                         i_flush,
  input logic                         i_ready,
  input msk_alu_pkg::ctl_state_t      i_state,
  input logic [msk_alu_pkg::XLEN-1:0] i_lfsr
);
  import msk_alu_pkg::*;

  int unsigned fail_count = 0; // Read by the testbench at the end

  a_ready_in_reset: assert property (@(posedge g_clk) !g_resetn |-> !i_ready)
    else begin
      fail_count++;
      $error("ready is high while reset is asserted");
    end

  a_ready_after_reset: assert property (@(posedge g_clk) !g_resetn |=> !i_ready)
    else begin
      fail_count++;
      $error("ready is high in the cycle after reset");
    end

  // No stale stage ready may leak out once flush has cleared the sequence
  a_no_ready_on_flush: assert property (@(posedge g_clk) i_flush |-> !i_ready ##1 !i_ready)
    else begin
      fail_count++;
      $error("ready is high during flush or in the cycle after it");
    end

  // Controller must be back in IDLE one edge after flush
  a_idle_after_flush: assert property (@(posedge g_clk) i_flush |=> i_state == IDLE)
    else begin
      fail_count++;
      $error("controller is not idle one cycle after flush");
    end

  a_seed_after_reset: assert property (@(posedge g_clk) $rose(g_resetn) |-> i_lfsr == PRNG_SEED)
    else begin
      fail_count++;
      $error("LFSR does not hold its seed after reset");
    end

endmodule

bind msk_alu msk_alu_props u_props (
  .g_clk    (g_clk),
  .g_resetn (g_resetn),
  .i_flush  (i_flush),
  .i_ready  (o_ready),
  .i_state  (u_ctl.state),
  .i_lfsr   (u_prng.lfsr)
);

// ==== msk_alu.sv ====
`timescale 1ns/1ps

module msk_alu (
  input  logic                 g_clk,
  input  logic                 g_resetn,
  input  logic                 i_valid,
  input  logic                 i_flush,
  input  logic                 i_prng_update,
  input  msk_alu_pkg::msk_op_t i_op,
  input  msk_alu_pkg::share_t  i_rs1,
  input  msk_alu_pkg::share_t  i_rs2,
  output logic                 o_ready,
  output msk_alu_pkg::share_t  o_rd
);
  import msk_alu_pkg::*;

  logic            do_logic;
  logic            do_addsub;
  logic            logic_ena;
  logic            addsub_ena;
  logic            logic_rdy;
  logic            addsub_rdy;
  logic [XLEN-1:0] prng_next;
  logic [XLEN-1:0] gs_fwd;
  share_t          operand_a;
  share_t          operand_b;
  share_t          sum;
  pg_t             pg;

  assign do_logic  = !i_flush && (i_op.op_not || i_op.op_and || i_op.op_ior || i_op.op_xor);
  assign do_addsub = !i_flush && (i_op.op_add || i_op.op_sub);

  // OR through De Morgan, SUB as a + ~b + 1, NOT as XOR with zero
  always_comb begin
    operand_a.s0 = i_rs1.s0;
    operand_a.s1 = i_op.op_ior ? ~i_rs1.s1 : i_rs1.s1;
    if (i_op.op_not) begin
      operand_b = '0;
    end else begin
      operand_b.s0 = i_rs2.s0;
      operand_b.s1 = (i_op.op_ior || i_op.op_sub) ? ~i_rs2.s1 : i_rs2.s1;
    end
  end

  msk_prng u_prng (
    .g_clk       (g_clk),
    .g_resetn    (g_resetn),
    .i_update    (o_ready || i_prng_update),
    .o_prng      (),
    .o_prng_next (prng_next)
  );

  msk_logic u_logic (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .i_ena    (logic_ena),
    .i_gs     (prng_next),
    .i_a      (operand_a),
    .i_b      (operand_b),
    .o_pg     (pg),
    .o_gs     (gs_fwd),
    .o_rdy    (logic_rdy)
  );

  msk_addsub u_addsub (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .i_flush  (i_flush),
    .i_ena    (addsub_ena),
    .i_sub    (i_op.op_sub),
    .i_gs     (gs_fwd),
    .i_pg     (pg),
    .o_sum    (sum),
    .o_rdy    (addsub_rdy)
  );

  // Add and sub also pass through the logic stage
  msk_alu_ctl u_ctl (
    .g_clk        (g_clk),
    .g_resetn     (g_resetn),
    .i_flush      (i_flush),
    .i_valid      (i_valid),
    .i_do_logic   (do_logic || do_addsub),
    .i_do_addsub  (do_addsub),
    .i_logic_rdy  (logic_rdy),
    .i_addsub_rdy (addsub_rdy),
    .o_logic_ena  (logic_ena),
    .o_addsub_ena (addsub_ena)
  );

  always_comb begin
    if (i_op.op_xor || i_op.op_not) begin
      o_rd.s0 = pg.p.s0;
      o_rd.s1 = i_op.op_not ? ~pg.p.s1 : pg.p.s1; // Invert plain value for NOT
    end else if (i_op.op_and || i_op.op_ior) begin
      o_rd.s0 = pg.g.s0;
      o_rd.s1 = i_op.op_ior ? ~pg.g.s1 : pg.g.s1;
    end else begin
      o_rd = sum;
    end
  end

  assign o_ready = (do_logic && logic_rdy) || (do_addsub && addsub_rdy);

endmodule

// ==== msk_alu_ctl.sv ====
`timescale 1ns/1ps

module msk_alu_ctl (
  input  logic g_clk,
  input  logic g_resetn,
  input  logic i_flush,
  input  logic i_valid,
  input  logic i_do_logic,
  input  logic i_do_addsub,
  input  logic i_logic_rdy,
  input  logic i_addsub_rdy,
  output logic o_logic_ena,
  output logic o_addsub_ena
);
  import msk_alu_pkg::*;

  ctl_state_t state;
  logic       req_logic;
  logic       req_addsub;

  assign req_logic  = i_valid && i_do_logic;
  assign req_addsub = i_valid && i_do_addsub;

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      state <= IDLE;
    end else if (i_flush) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (req_logic) begin
            state <= LOGIC;
          end
        end
        LOGIC: begin
          if (i_logic_rdy) begin
            state <= req_addsub ? ARITH : IDLE;
          end
        end
        ARITH:   state <= i_addsub_rdy ? IDLE : ARITH;
        default: state <= IDLE;
      endcase
    end
  end

  // Logic stage fires once per request
  assign o_logic_ena  = req_logic && (state == IDLE);
  assign o_addsub_ena = req_addsub && (state != IDLE);

endmodule

// ==== msk_addsub.sv ====
`timescale 1ns/1ps

module msk_addsub (
  input  logic                         g_clk,
  input  logic                         g_resetn,
  input  logic                         i_flush,
  input  logic                         i_ena,
  input  logic                         i_sub,
  input  logic [msk_alu_pkg::XLEN-1:0] i_gs,
  input  msk_alu_pkg::pg_t             i_pg,
  output msk_alu_pkg::share_t          o_sum,
  output logic                         o_rdy
);
  import msk_alu_pkg::*;

  logic [SEQ_W-1:0] seq_cnt;
  logic             ini;
  logic             done;
  logic             step_ena;
  logic [4:0]       shamt;
  logic [XLEN-1:0]  cin_word;
  logic [XLEN-1:0]  gs_step;
  pg_t              pg_in;
  pg_t              pg_j;
  pg_t              pg_fb;
  share_t           tg_a_d, tg_a_q;
  share_t           tg_b_d, tg_b_q;
  share_t           tp_a_d, tp_a_q;
  share_t           tp_b_d, tp_b_q;

  assign done     = (seq_cnt == SEQ_DONE);
  assign ini      = i_ena && (seq_cnt == SEQ_FIRST);
  assign step_ena = i_ena && !done;

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      seq_cnt <= SEQ_FIRST;
    end else if (i_flush || done) begin
      seq_cnt <= SEQ_FIRST;
    end else if (i_ena) begin
      seq_cnt <= seq_cnt + 1'b1;
    end
  end

  // First step takes the logic stage output, later steps loop back
  assign pg_in   = ini ? i_pg : pg_fb;
  assign gs_step = ini ? i_gs : pg_in.p.s0;

  always_comb begin
    case (seq_cnt)
      3'd1:    shamt = 5'd1;
      3'd2:    shamt = 5'd2;
      3'd3:    shamt = 5'd4;
      3'd4:    shamt = 5'd8;
      3'd5:    shamt = 5'd16;
      default: shamt = 5'd0;
    endcase
  end

  // Carry-in enters just below the shifted group
  always_comb begin
    if (shamt != 5'd0) begin
      cin_word  = {{(XLEN-1){1'b0}}, i_sub} << (shamt - 5'd1);
      pg_j.g.s0 = pg_in.g.s0 << shamt;
      pg_j.g.s1 = (pg_in.g.s1 << shamt) | cin_word;
      pg_j.p.s0 = pg_in.p.s0 << shamt;
      pg_j.p.s1 = pg_in.p.s1 << shamt;
    end else begin
      cin_word = '0;
      pg_j     = '0;
    end
  end

  always_comb begin
    // Group generate g_k ^ (g_j & p_k)
    tg_a_d.s0 = pg_in.g.s0 ^ (pg_j.g.s0 & pg_in.p.s0);
    tg_a_d.s1 = pg_in.g.s1 ^ (pg_j.g.s1 & pg_in.p.s0);
    tg_b_d.s0 = pg_j.g.s0 & pg_in.p.s1;
    tg_b_d.s1 = pg_j.g.s1 & pg_in.p.s1;
    // Group propagate p_k & p_j, remasked
    tp_a_d.s0 = gs_step ^ (pg_in.p.s0 & pg_j.p.s0);
    tp_a_d.s1 = gs_step ^ (pg_in.p.s0 & pg_j.p.s1);
    tp_b_d.s0 = pg_in.p.s1 & pg_j.p.s0;
    tp_b_d.s1 = pg_in.p.s1 & pg_j.p.s1;
  end

  always_ff @(posedge g_clk) begin
    if (step_ena) begin
      tg_a_q <= tg_a_d;
      tg_b_q <= tg_b_d;
      tp_a_q <= tp_a_d;
      tp_b_q <= tp_b_d;
    end
  end

  always_comb begin
    pg_fb.g.s0 = tg_a_q.s0 ^ tg_b_q.s0;
    pg_fb.g.s1 = tg_a_q.s1 ^ tg_b_q.s1;
    pg_fb.p.s0 = tp_a_q.s0 ^ tp_b_q.s0;
    pg_fb.p.s1 = tp_a_q.s1 ^ tp_b_q.s1;
  end

  // Sum bit is p_i ^ carry into bit i
  always_comb begin
    o_sum.s0 = i_pg.p.s0 ^ {pg_fb.g.s0[XLEN-2:0], 1'b0};
    o_sum.s1 = i_pg.p.s1 ^ {pg_fb.g.s1[XLEN-2:0], i_sub};
  end

  assign o_rdy = done;

endmodule

// ==== msk_logic.sv ====
`timescale 1ns/1ps

module msk_logic (
  input  logic                         g_clk,
  input  logic                         g_resetn,
  input  logic                         i_ena,
  input  logic [msk_alu_pkg::XLEN-1:0] i_gs,
  input  msk_alu_pkg::share_t          i_a,
  input  msk_alu_pkg::share_t          i_b,
  output msk_alu_pkg::pg_t             o_pg,
  output logic [msk_alu_pkg::XLEN-1:0] o_gs,
  output logic                         o_rdy
);
  import msk_alu_pkg::*;

  share_t p_d, p_q;
  share_t t_a_d, t_a_q; // Cross terms with share 0 of a
  share_t t_b_d, t_b_q; // Cross terms with share 1 of a

  always_comb begin
    p_d.s0   = i_a.s0 ^ i_b.s0;
    p_d.s1   = i_a.s1 ^ i_b.s1;
    // Fresh mask folded in before the register
    t_a_d.s0 = i_gs ^ (i_a.s0 & i_b.s0);
    t_a_d.s1 = i_gs ^ (i_a.s0 & i_b.s1);
    t_b_d.s0 = i_a.s1 & i_b.s0;
    t_b_d.s1 = i_a.s1 & i_b.s1;
  end

  always_ff @(posedge g_clk) begin
    if (i_ena) begin
      p_q   <= p_d;
      t_a_q <= t_a_d;
      t_b_q <= t_b_d;
    end
  end

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      o_rdy <= 1'b0;
    end else begin
      o_rdy <= i_ena;
    end
  end

  // Recombine only after the terms are registered
  always_comb begin
    o_pg.p    = p_q;
    o_pg.g.s0 = t_a_q.s0 ^ t_b_q.s0;
    o_pg.g.s1 = t_a_q.s1 ^ t_b_q.s1;
  end

  assign o_gs = i_a.s1; // Reused as randomness by the carry steps

endmodule

// ==== msk_prng.sv ====
`timescale 1ns/1ps

module msk_prng (
  input  logic                         g_clk,
  input  logic                         g_resetn,
  input  logic                         i_update,
  output logic [msk_alu_pkg::XLEN-1:0] o_prng,
  output logic [msk_alu_pkg::XLEN-1:0] o_prng_next
);
  import msk_alu_pkg::*;

  logic [XLEN-1:0] lfsr;
  logic            feedback;

  // Fibonacci taps 31 21 1 0
  assign feedback    = lfsr[XLEN-1] ~^ lfsr[21] ~^ lfsr[1] ~^ lfsr[0];
  assign o_prng_next = {lfsr[XLEN-2:0], feedback};
  assign o_prng      = lfsr;

  always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
      lfsr <= PRNG_SEED;
    end else if (i_update) begin
      lfsr <= o_prng_next;
    end
  end

endmodule

// ==== msk_alu_pkg.sv ====
package msk_alu_pkg;

  localparam int XLEN = 32;

  // LFSR state after reset
  localparam logic [XLEN-1:0] PRNG_SEED = 32'h6789_abcd;

  // Add/sub sequence counter
  localparam int SEQ_W = 3;
  localparam logic [SEQ_W-1:0] SEQ_FIRST = 3'd1;
  localparam logic [SEQ_W-1:0] SEQ_DONE  = 3'd6;

  // One masked word, plain value is s0 ^ s1
  typedef struct packed {
    logic [XLEN-1:0] s0;
    logic [XLEN-1:0] s1;
  } share_t;

  // Propagate doubles as XOR result, generate as AND result
  typedef struct packed {
    share_t p;
    share_t g;
  } pg_t;

  typedef struct packed {
    logic op_not;
    logic op_and;
    logic op_ior;
    logic op_xor;
    logic op_add;
    logic op_sub;
  } msk_op_t;

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    LOGIC = 2'd1,
    ARITH = 2'd2
  } ctl_state_t;

endpackage
